/* build.f */
+incdir+design
design/rift_pkg.sv
design/front_end.sv
design/instr_fifo.sv
design/back_end.sv
design/rift_core.sv
tests/rift_core_assert.sv
tests/rift_core_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module rift_core_tb -f build.f \
	-Mdir obj_dir -o rift_sim || { echo "build error"; exit 1; }
./obj_dir/rift_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
test -s sim.log || { echo "no simulation log"; exit 1; }
grep -q "tests failed" sim.log && exit 1 || exit 0

/* tests/rift_core_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module rift_core_tb;

	localparam int num_tests = 6;
	localparam int cycles_per_test = 400;
	localparam int max_cycles = num_tests * cycles_per_test; // limit for the whole run
	localparam int mem_words = 256;

	logic clk = 1'b0;
	logic arst_n;
	logic ifu_req_ready;
	rift_pkg::word_t ifu_rsp_data;
	logic ifu_rsp_valid;
	logic ifu_req_valid;
	logic ifu_req_kill;
	rift_pkg::addr_t ifu_addr;
	rift_pkg::retire_t retire;

	rift_pkg::word_t mem [mem_words]; // instruction memory
	rift_pkg::word_t regs [32]; // last retired value per rd
	int retire_cnt [mem_words]; // retires per word slot
	logic [63:0] stream [$]; // pc and value of each retire
	logic [63:0] ref_stream [$];
	logic pending = 1'b0; // one fetch outstanding
	rift_pkg::addr_t req_addr;
	int lat_left;
	logic random_bp = 1'b0; // random ready and latency on
	logic mem_live = 1'b0; // memory holds the program that is running
	int cycles = 0;
	int kills = 0;
	int errors = 0;
	int passed = 0;
	int failed = 0;
	int assert_base = 0;
	rift_pkg::addr_t halt_pc;

	rift_core i_dut (
		.clk(clk),
		.arst_n(arst_n),
		.ifu_req_ready(ifu_req_ready),
		.ifu_rsp_data(ifu_rsp_data),
		.ifu_rsp_valid(ifu_rsp_valid),
		.ifu_req_valid(ifu_req_valid),
		.ifu_req_kill(ifu_req_kill),
		.ifu_addr(ifu_addr),
		.retire(retire)
	);

	bind rift_core rift_core_retire_assert i_retire_assert (
		.clk(clk),
		.arst_n(arst_n),
		.retire(retire),
		.ifu_req_valid(ifu_req_valid),
		.ifu_req_ready(ifu_req_ready),
		.ifu_req_kill(ifu_req_kill),
		.ifu_addr(ifu_addr)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout: run did not finish within %0d cycles", max_cycles);
			$display("tests failed");
			$finish;
		end
	end

	// fetch memory, one request at a time, latency 1 to 4
	always @(posedge clk) begin
		ifu_rsp_valid <= 1'b0;
		ifu_req_ready <= random_bp ? ($urandom % 4 != 0) : 1'b1;
		kills <= !arst_n ? 0 : kills + int'(ifu_req_kill);
		if (!arst_n || ifu_req_kill) begin
			pending <= 1'b0; // killed request is never answered
		end else if (pending) begin
			if (lat_left == 0) begin
				ifu_rsp_valid <= 1'b1;
				ifu_rsp_data <= mem[req_addr[9:2]];
				pending <= 1'b0;
			end else begin
				lat_left <= lat_left - 1;
			end
		end else if (ifu_req_valid && ifu_req_ready) begin
			pending <= 1'b1;
			req_addr <= ifu_addr;
			lat_left <= random_bp ? int'($urandom % 4) : 0;
		end
	end

	always @(negedge clk) begin
		if (retire.valid) begin
			if (mem_live) begin
				check("retire.instr", retire.instr, mem[retire.pc[9:2]]);
			end
			if (retire.rd != 5'd0) begin
				regs[retire.rd] = retire.value;
			end
			retire_cnt[retire.pc[9:2]] += 1;
			stream.push_back({retire.pc, retire.value});
		end
	end

	function automatic rift_pkg::word_t addi(input int rd, input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
	endfunction

	function automatic rift_pkg::word_t add(input int rd, input int rs1, input int rs2);
		return {7'b0000000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
	endfunction

	function automatic rift_pkg::word_t sub(input int rd, input int rs1, input int rs2);
		return {7'b0100000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
	endfunction

	// f3 000 beq, 001 bne
	function automatic rift_pkg::word_t branch(input logic [2:0] f3, input int rs1, input int rs2,
		input int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic rift_pkg::word_t jal(input int rd, input int off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
	endfunction

	function automatic rift_pkg::word_t jalr(input int rd, input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b1100111};
	endfunction

	task automatic check(input string name, input rift_pkg::word_t got, input rift_pkg::word_t exp);
		assert (got == exp) else begin
			$display("error %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic require(input logic cond, input string what);
		assert (cond) else begin
			$display("%s", what);
			errors++;
		end
	endtask

	task automatic check_reg(input int r, input rift_pkg::word_t exp);
		check($sformatf("x%0d", r), regs[r], exp);
	endtask

	// memory between tests, a nop that carries its own slot number
	task automatic begin_test();
		mem_live = 1'b0;
		@(negedge clk);
		errors = 0;
		assert_base = i_dut.i_retire_assert.fail_count;
		for (int i = 0; i < mem_words; i++) begin
			mem[i] = addi(0, 0, i);
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		arst_n <= 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		check("ifu_req_valid", ifu_req_valid, 0); // all quiet in reset
		check("ifu_req_kill", ifu_req_kill, 0);
		check("retire.valid", retire.valid, 0);
		stream.delete();
		foreach (retire_cnt[i]) retire_cnt[i] = 0;
		foreach (regs[i]) regs[i] = '0;
		@(posedge clk);
		arst_n <= 1'b1;
		mem_live = 1'b1;
	endtask

	task automatic wait_retire(input rift_pkg::addr_t pc);
		@(negedge clk);
		while (!(retire.valid && retire.pc == pc)) begin
			@(negedge clk);
		end
		@(posedge clk); // monitor has taken this retire
	endtask

	task automatic finish_test(input int num, input string name);
		errors += i_dut.i_retire_assert.fail_count - assert_base;
		if (errors == 0) begin
			passed++;
			$display("test %0d %s: ok", num, name);
		end else begin
			failed++;
			$display("test %0d %s: %0d errors", num, name, errors);
		end
	endtask

	task automatic load_straight();
		mem[0] = addi(1, 0, 5);
		mem[1] = addi(2, 0, -3);
		mem[2] = add(3, 1, 2);
		mem[3] = sub(4, 1, 2);
		mem[4] = addi(0, 1, 7); // x0 must ignore this
		mem[5] = add(5, 0, 4);
		mem[6] = sub(6, 2, 1);
		mem[7] = jal(0, 0); // halt loop
		halt_pc = 32'd28;
	endtask

	task automatic check_straight();
		check_reg(1, 32'h5);
		check_reg(2, 32'hffff_fffd);
		check_reg(3, 32'h2);
		check_reg(4, 32'h8);
		check_reg(5, 32'h8);
		check_reg(6, 32'hffff_fff8);
	endtask

	initial begin
		arst_n = 1'b0;
		ifu_req_ready = 1'b0;
		ifu_rsp_valid = 1'b0;
		ifu_rsp_data = '0;
		void'($urandom(32'ha0671f1e));

		begin_test();
		load_straight();
		apply_reset();
		wait_retire(halt_pc);
		check_straight();
		finish_test(1, "straight line");

		begin_test();
		mem[0] = addi(1, 0, 0);
		mem[1] = addi(2, 0, 5);
		mem[2] = addi(1, 1, 1); // loop body
		mem[3] = branch(3'b001, 1, 2, -4); // backward, taken four times
		mem[4] = addi(3, 1, 10);
		mem[5] = jal(0, 0);
		halt_pc = 32'd20;
		apply_reset();
		wait_retire(halt_pc);
		check_reg(1, 32'h5);
		check_reg(3, 32'hf);
		check("retires of pc 08", retire_cnt[2], 5);
		check("retires of pc 0c", retire_cnt[3], 5);
		check("retires of pc 10", retire_cnt[4], 1);
		finish_test(2, "backward loop");

		begin_test();
		mem[0] = addi(1, 0, 3);
		mem[1] = addi(2, 0, 3);
		mem[2] = branch(3'b000, 1, 2, 12); // forward beq, taken
		mem[3] = addi(3, 0, 1);
		mem[4] = addi(4, 0, 2);
		mem[5] = addi(5, 0, 9);
		mem[6] = jal(0, 0);
		halt_pc = 32'd24;
		apply_reset();
		wait_retire(halt_pc);
		check_reg(5, 32'h9);
		require(retire_cnt[3] == 0 && retire_cnt[4] == 0, "skipped instruction retired");
		require(kills > 0, "ifu_req_kill never pulsed on the mispredict");
		finish_test(3, "forward taken branch");

		begin_test();
		mem[0] = addi(1, 0, 24);
		mem[1] = jal(2, 8);
		mem[2] = addi(9, 0, 1);
		mem[3] = jalr(3, 1, 0); // to pc 24
		mem[4] = addi(9, 0, 2);
		mem[5] = addi(9, 0, 3);
		mem[6] = addi(4, 2, 100);
		mem[7] = jal(0, 0);
		halt_pc = 32'd28;
		apply_reset();
		wait_retire(halt_pc);
		check_reg(2, 32'h8);
		check_reg(3, 32'h10);
		check_reg(4, 32'h6c);
		require(retire_cnt[2] + retire_cnt[4] + retire_cnt[5] == 0, "jumped-over code retired");
		finish_test(4, "jal and jalr");

		begin_test();
		mem[0] = addi(1, 0, 0);
		mem[1] = addi(2, 0, 8);
		mem[2] = addi(3, 0, 0);
		mem[3] = addi(1, 1, 1);
		mem[4] = add(3, 3, 1);
		mem[5] = sub(4, 3, 1);
		mem[6] = addi(5, 4, 3);
		mem[7] = branch(3'b001, 1, 2, -16);
		mem[8] = branch(3'b000, 1, 2, 8);
		mem[9] = addi(6, 0, 1);
		mem[10] = add(7, 3, 2);
		mem[11] = jal(0, 0);
		halt_pc = 32'd44;
		random_bp <= 1'b0;
		apply_reset();
		wait_retire(halt_pc);
		ref_stream = stream; // stall-free reference
		random_bp <= 1'b1;
		apply_reset();
		wait_retire(halt_pc);
		random_bp <= 1'b0;
		check("stream length", stream.size(), ref_stream.size());
		for (int i = 0; i < stream.size() && i < ref_stream.size(); i++) begin
			check("retire.pc", stream[i][63:32], ref_stream[i][63:32]);
			check("retire.value", stream[i][31:0], ref_stream[i][31:0]);
		end
		check_reg(3, 32'h24);
		check_reg(5, 32'h1f);
		check_reg(7, 32'h2c);
		finish_test(5, "random back-pressure");

		begin_test();
		load_straight();
		apply_reset();
		wait_retire(32'd12);
		apply_reset(); // mid-run
		@(posedge clk);
		@(negedge clk);
		check("ifu_req_valid", ifu_req_valid, 1);
		check("ifu_addr", ifu_addr, `RIFT_RESET_PC);
		wait_retire(halt_pc);
		check_straight();
		finish_test(6, "reset mid-run");

		$display("passed %0d, failed %0d", passed, failed);
		if (failed == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tests/rift_core_assert.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rift_params.svh"

module rift_core_retire_assert (
	input wire clk,
	input wire arst_n,
	input wire rift_pkg::retire_t retire,
	input wire ifu_req_valid,
	input wire ifu_req_ready,
	input wire ifu_req_kill,
	input wire rift_pkg::addr_t ifu_addr
);

	rift_pkg::word_t shadow [32]; // architectural state as seen at retire
	rift_pkg::word_t ins;
	rift_pkg::word_t rs1_val;
	rift_pkg::word_t rs2_val;
	rift_pkg::word_t imm_i;
	rift_pkg::word_t imm_b;
	rift_pkg::word_t imm_j;
	rift_pkg::word_t exp_value;
	rift_pkg::addr_t exp_next; // pc that must retire after this one
	rift_pkg::addr_t next_pc;
	logic has_value;
	int pc_fails = 0;
	int value_fails = 0;
	int hold_fails = 0;
	int fail_count; // read by the testbench

	assign fail_count = pc_fails + value_fails + hold_fails;
	assign ins = retire.instr;
	assign rs1_val = (ins[19:15] == 5'd0) ? '0 : shadow[ins[19:15]];
	assign rs2_val = (ins[24:20] == 5'd0) ? '0 : shadow[ins[24:20]];
	assign imm_i = {{20{ins[31]}}, ins[31:20]};
	assign imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
	assign imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

	// rv32i semantics of the retired word
	always_comb begin
		has_value = 1'b1;
		exp_value = '0;
		exp_next = retire.pc + 32'd4;
		case (ins[6:0])
			7'b0010011: exp_value = rs1_val + imm_i; // addi
			7'b0110011: exp_value = ins[30] ? rs1_val - rs2_val : rs1_val + rs2_val;
			7'b1101111: begin
				exp_value = retire.pc + 32'd4; // link
				exp_next = retire.pc + imm_j;
			end
			7'b1100111: begin
				exp_value = retire.pc + 32'd4;
				exp_next = (rs1_val + imm_i) & ~32'd1;
			end
			7'b1100011: begin
				has_value = 1'b0;
				if ((rs1_val == rs2_val) != ins[12]) begin // funct3 lsb picks bne
					exp_next = retire.pc + imm_b;
				end
			end
			default: has_value = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			next_pc <= `RIFT_RESET_PC; // first retire comes from the reset pc
		end else if (retire.valid) begin
			next_pc <= exp_next;
		end
	end

	always_ff @(posedge clk) begin
		if (retire.valid && has_value && ins[11:7] != 5'd0) begin
			shadow[ins[11:7]] <= exp_value;
		end
	end

	assert property (@(posedge clk) disable iff (!arst_n)
		retire.valid |-> retire.pc == next_pc)
		else begin
			$error("retired pc %h, expected %h", retire.pc, next_pc);
			pc_fails++;
		end

	assert property (@(posedge clk) disable iff (!arst_n)
		retire.valid && has_value |-> retire.value == exp_value)
		else begin
			$error("retire.value %h at pc %h, expected %h", retire.value, retire.pc, exp_value);
			value_fails++;
		end

	// a kill is the only way out of a pending request
	assert property (@(posedge clk) disable iff (!arst_n)
		ifu_req_valid && !ifu_req_ready |=> ifu_req_kill || (ifu_req_valid && $stable(ifu_addr)))
		else begin
			$error("fetch request dropped or changed before ready");
			hold_fails++;
		end

endmodule

`default_nettype wire

/* design/rift_core.sv */
`timescale 1ns/1ns
`default_nettype none

module rift_core (
	input wire clk,
	input wire arst_n,
	input wire ifu_req_ready,
	input wire rift_pkg::word_t ifu_rsp_data,
	input wire ifu_rsp_valid,
	output logic ifu_req_valid,
	output logic ifu_req_kill,
	output rift_pkg::addr_t ifu_addr,
	output rift_pkg::retire_t retire
);

	logic fifo_push;
	logic fifo_pop;
	logic fifo_full;
	logic fifo_empty;
	logic fe_flush; // front end saw a wrong prediction
	logic be_flush; // back end has dropped the wrong path
	logic mispredict;
	logic mispredict_set;
	logic mispredict_rst;
	rift_pkg::micro_instr_t push_data;
	rift_pkg::micro_instr_t pop_data;
	rift_pkg::bru_res_t bru_res;
	rift_pkg::bru_res_t bru_res_gated;
	rift_pkg::jalr_res_t jalr_res;
	rift_pkg::jalr_res_t jalr_res_gated;

	assign mispredict_set = fe_flush && !be_flush;
	assign mispredict_rst = be_flush;

	// wrong-path results never reach the front end
	always_comb begin
		bru_res_gated = bru_res;
		bru_res_gated.valid = bru_res.valid && !mispredict;
		jalr_res_gated = jalr_res;
		jalr_res_gated.valid = jalr_res.valid && !mispredict;
	end

	front_end i_front_end (
		.clk(clk),
		.arst_n(arst_n),
		.fifo_full(fifo_full),
		.bru_res(bru_res_gated),
		.jalr_res(jalr_res_gated),
		.ifu_req_ready(ifu_req_ready),
		.ifu_rsp_data(ifu_rsp_data),
		.ifu_rsp_valid(ifu_rsp_valid),
		.push(fifo_push),
		.push_data(push_data),
		.flush(fe_flush),
		.ifu_req_valid(ifu_req_valid),
		.ifu_req_kill(ifu_req_kill),
		.ifu_addr(ifu_addr)
	);

	instr_fifo i_instr_fifo (
		.clk(clk),
		.arst_n(arst_n),
		.push(fifo_push),
		.push_data(push_data),
		.pop(fifo_pop),
		.flush(fe_flush),
		.full(fifo_full),
		.empty(fifo_empty),
		.pop_data(pop_data)
	);

	back_end i_back_end (
		.clk(clk),
		.arst_n(arst_n),
		.fifo_empty(fifo_empty || mispredict), // hold issue until squash is done
		.pop_data(pop_data),
		.is_mispredict(mispredict),
		.pop(fifo_pop),
		.bru_res(bru_res),
		.jalr_res(jalr_res),
		.flush(be_flush),
		.retire(retire)
	);

	// set/reset flag, reset wins
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mispredict <= 1'b0;
		end else if (mispredict_rst) begin
			mispredict <= 1'b0;
		end else if (mispredict_set) begin
			mispredict <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* design/back_end.sv */
`timescale 1ns/1ns
`default_nettype none

module back_end (
	input wire clk,
	input wire arst_n,
	input wire fifo_empty,
	input wire rift_pkg::micro_instr_t pop_data,
	input wire is_mispredict,
	output logic pop,
	output rift_pkg::bru_res_t bru_res,
	output rift_pkg::jalr_res_t jalr_res,
	output logic flush,
	output rift_pkg::retire_t retire
);

	rift_pkg::word_t rf [32]; // entry 0 never written
	rift_pkg::micro_instr_t is_uop; // issue stage
	rift_pkg::micro_instr_t ex_uop; // execute stage
	logic is_vld;
	logic ex_vld;
	logic ex_live;
	logic ex_wen;
	logic ex_taken;
	rift_pkg::word_t is_rs1_val;
	rift_pkg::word_t is_rs2_val;
	rift_pkg::word_t ex_a;
	rift_pkg::word_t ex_b;
	rift_pkg::word_t ex_result;

	// no stalls in the pipe, so take whatever is at the head
	assign pop = !fifo_empty;

	// everything in issue and execute is younger than a mispredicted branch
	assign ex_live = ex_vld && !is_mispredict;
	assign ex_wen = ex_live && (ex_uop.rd != '0);

	function automatic rift_pkg::word_t read_reg(input rift_pkg::reg_idx_t idx);
		if (idx == '0) begin
			return '0;
		end
		if (ex_wen && ex_uop.rd == idx) begin
			return ex_result; // bypass from execute
		end
		return rf[idx];
	endfunction

	always_comb begin
		is_rs1_val = read_reg(is_uop.rs1);
		is_rs2_val = read_reg(is_uop.rs2);
	end

	always_comb begin
		case (ex_uop.op)
			rift_pkg::op_addi: ex_result = ex_a + ex_uop.imm;
			rift_pkg::op_add: ex_result = ex_a + ex_b;
			rift_pkg::op_sub: ex_result = ex_a - ex_b;
			rift_pkg::op_jal, rift_pkg::op_jalr: ex_result = ex_uop.pc + 'd4; // link
			default: ex_result = '0;
		endcase
	end

	assign ex_taken = (ex_uop.op == rift_pkg::op_beq) ? (ex_a == ex_b) : (ex_a != ex_b);

	// resolved in execute, one report per branch
	assign bru_res.valid = ex_vld && (ex_uop.op inside {rift_pkg::op_beq, rift_pkg::op_bne});
	assign bru_res.taken = ex_taken;
	assign jalr_res.valid = ex_vld && (ex_uop.op == rift_pkg::op_jalr);
	assign jalr_res.target = (ex_a + ex_uop.imm) & ~rift_pkg::addr_t'(1);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			is_vld <= 1'b0;
			ex_vld <= 1'b0;
			flush <= 1'b0;
			retire <= '0;
		end else begin
			is_vld <= pop && !is_mispredict;
			ex_vld <= is_vld && !is_mispredict; // squash younger work
			flush <= is_mispredict && !flush; // single pulse, clears the flag
			retire.valid <= ex_live;
			retire.pc <= ex_uop.pc;
			retire.instr <= ex_uop.instr;
			retire.rd <= ex_uop.rd;
			retire.value <= ex_result;
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			is_uop <= pop_data;
		end
		ex_uop <= is_uop;
		ex_a <= is_rs1_val;
		ex_b <= is_rs2_val;
		if (ex_wen) begin
			rf[ex_uop.rd] <= ex_result;
		end
	end

endmodule

`default_nettype wire

/* design/instr_fifo.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rift_params.svh"

module instr_fifo (
	input wire clk,
	input wire arst_n,
	input wire push,
	input wire rift_pkg::micro_instr_t push_data,
	input wire pop,
	input wire flush,
	output logic full,
	output logic empty,
	output rift_pkg::micro_instr_t pop_data
);

	logic [`RIFT_FIFO_AW:0] wptr; // msb is the wrap bit
	logic [`RIFT_FIFO_AW:0] rptr;
	logic do_push;
	logic do_pop;
	rift_pkg::micro_instr_t mem [1 << `RIFT_FIFO_AW];

	assign empty = (wptr == rptr);
	assign full = (wptr[`RIFT_FIFO_AW] != rptr[`RIFT_FIFO_AW])
		&& (wptr[`RIFT_FIFO_AW-1:0] == rptr[`RIFT_FIFO_AW-1:0]);
	assign pop_data = mem[rptr[`RIFT_FIFO_AW-1:0]]; // head, valid when not empty

	assign do_push = push && !full && !flush; // push during flush is dropped
	assign do_pop = pop && !empty;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wptr <= '0;
			rptr <= '0;
		end else if (flush) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (do_push) begin
				wptr <= wptr + 1'b1;
			end
			if (do_pop) begin
				rptr <= rptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wptr[`RIFT_FIFO_AW-1:0]] <= push_data;
		end
	end

endmodule

`default_nettype wire

/* design/front_end.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rift_params.svh"

module front_end (
	input wire clk,
	input wire arst_n,
	input wire fifo_full,
	input wire rift_pkg::bru_res_t bru_res,
	input wire rift_pkg::jalr_res_t jalr_res,
	input wire ifu_req_ready,
	input wire rift_pkg::word_t ifu_rsp_data,
	input wire ifu_rsp_valid,
	output logic push,
	output rift_pkg::micro_instr_t push_data,
	output logic flush,
	output logic ifu_req_valid,
	output logic ifu_req_kill,
	output rift_pkg::addr_t ifu_addr
);

	typedef enum logic [2:0] {
		st_idle,
		st_request,
		st_wait_rsp,
		st_hold,
		st_wait_jalr
	} fetch_state_e;

	fetch_state_e state;
	rift_pkg::addr_t pc; // address of the instruction in flight
	rift_pkg::addr_t seq_pc;
	rift_pkg::addr_t tgt_pc;
	rift_pkg::addr_t pc_next;
	rift_pkg::word_t rsp_buf; // response parked while FIFO is full
	rift_pkg::word_t cur;
	rift_pkg::word_t imm_i;
	rift_pkg::word_t imm_b;
	rift_pkg::word_t imm_j;
	rift_pkg::micro_instr_t dec;
	logic have_instr;
	logic is_br;

	logic [`RIFT_BQ_AW:0] bq_wptr; // extra bit tells full from empty
	logic [`RIFT_BQ_AW:0] bq_rptr;
	logic bq_taken [1 << `RIFT_BQ_AW];
	rift_pkg::addr_t bq_alt [1 << `RIFT_BQ_AW]; // address to restart at if wrong
	logic bq_full;

	assign cur = (state == st_hold) ? rsp_buf : ifu_rsp_data;
	assign have_instr = (state == st_hold) || (state == st_wait_rsp && ifu_rsp_valid);

	// immediates of the I, B and J formats
	assign imm_i = {{(`RIFT_XLEN-12){cur[31]}}, cur[31:20]};
	assign imm_b = {{(`RIFT_XLEN-13){cur[31]}}, cur[31], cur[7], cur[30:25], cur[11:8], 1'b0};
	assign imm_j = {{(`RIFT_XLEN-21){cur[31]}}, cur[31], cur[19:12], cur[20], cur[30:21], 1'b0};

	always_comb begin
		dec = '0;
		dec.op = rift_pkg::op_nop; // anything unknown retires as nop
		dec.rs1 = cur[19:15];
		dec.rs2 = cur[24:20];
		dec.pc = pc;
		dec.instr = cur;
		case (cur[6:0])
			7'b0010011: begin
				if (cur[14:12] == 3'b000) begin
					dec.op = rift_pkg::op_addi;
					dec.imm = imm_i;
				end
			end
			7'b0110011: begin
				if (cur[14:12] == 3'b000 && cur[31:25] == 7'b0000000) begin
					dec.op = rift_pkg::op_add;
				end else if (cur[14:12] == 3'b000 && cur[31:25] == 7'b0100000) begin
					dec.op = rift_pkg::op_sub;
				end
			end
			7'b1100011: begin
				if (cur[14:13] == 2'b00) begin // funct3 000 beq, 001 bne
					dec.op = cur[12] ? rift_pkg::op_bne : rift_pkg::op_beq;
					dec.imm = imm_b;
					dec.pred_taken = imm_b[`RIFT_XLEN-1]; // backward means taken
				end
			end
			7'b1101111: begin
				dec.op = rift_pkg::op_jal;
				dec.imm = imm_j;
			end
			7'b1100111: begin
				if (cur[14:12] == 3'b000) begin
					dec.op = rift_pkg::op_jalr;
					dec.imm = imm_i;
				end
			end
			default: dec.op = rift_pkg::op_nop;
		endcase
		if (dec.op inside {rift_pkg::op_addi, rift_pkg::op_add, rift_pkg::op_sub,
			rift_pkg::op_jal, rift_pkg::op_jalr}) begin
			dec.rd = cur[11:7];
		end
	end

	assign is_br = dec.op inside {rift_pkg::op_beq, rift_pkg::op_bne};
	assign seq_pc = pc + 'd4;
	assign tgt_pc = pc + dec.imm;
	assign pc_next = (dec.op == rift_pkg::op_jal || dec.pred_taken) ? tgt_pc : seq_pc;

	// stall a branch while the prediction queue has no room
	assign bq_full = (bq_wptr ^ bq_rptr) == {1'b1, {`RIFT_BQ_AW{1'b0}}};
	assign push = have_instr && !fifo_full && !(is_br && bq_full) && !flush;
	assign push_data = dec;

	// oldest prediction against the resolved outcome
	assign flush = bru_res.valid && (bru_res.taken != bq_taken[bq_rptr[`RIFT_BQ_AW-1:0]]);

	assign ifu_req_valid = (state == st_request) && !flush; // never together with kill
	assign ifu_req_kill = flush;
	assign ifu_addr = pc;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			pc <= `RIFT_RESET_PC;
		end else if (flush) begin
			state <= st_request; // restart on the other path
			pc <= bq_alt[bq_rptr[`RIFT_BQ_AW-1:0]];
		end else begin
			case (state)
				st_idle: state <= st_request;
				st_request: begin
					if (ifu_req_ready) begin
						state <= st_wait_rsp;
					end
				end
				st_wait_rsp, st_hold: begin
					if (push) begin
						pc <= pc_next;
						state <= (dec.op == rift_pkg::op_jalr) ? st_wait_jalr : st_request;
					end else if (have_instr) begin
						state <= st_hold; // FIFO or queue full
					end
				end
				st_wait_jalr: begin
					if (jalr_res.valid) begin
						pc <= jalr_res.target;
						state <= st_request;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_wait_rsp && ifu_rsp_valid) begin
			rsp_buf <= ifu_rsp_data;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bq_wptr <= '0;
			bq_rptr <= '0;
		end else if (flush) begin
			bq_wptr <= '0; // every queued branch is on the wrong path
			bq_rptr <= '0;
		end else begin
			if (push && is_br) begin
				bq_wptr <= bq_wptr + 1'b1;
			end
			if (bru_res.valid) begin
				bq_rptr <= bq_rptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push && is_br) begin
			bq_taken[bq_wptr[`RIFT_BQ_AW-1:0]] <= dec.pred_taken;
			bq_alt[bq_wptr[`RIFT_BQ_AW-1:0]] <= dec.pred_taken ? seq_pc : tgt_pc;
		end
	end

endmodule

`default_nettype wire

/* design/rift_pkg.sv */
`default_nettype none
`include "rift_params.svh"

package rift_pkg;

	typedef logic [`RIFT_XLEN-1:0] word_t; // register and bus data
	typedef logic [`RIFT_XLEN-1:0] addr_t; // instruction address
	typedef logic [4:0] reg_idx_t; // x0..x31

	typedef enum logic [2:0] {
		op_nop,
		op_addi,
		op_add,
		op_sub,
		op_beq,
		op_bne,
		op_jal,
		op_jalr
	} op_e;

	typedef struct packed {
		op_e op;
		reg_idx_t rd; // zero when nothing is written back
		reg_idx_t rs1;
		reg_idx_t rs2;
		word_t imm; // sign extended, shifted for branch and jal
		addr_t pc;
		word_t instr; // raw word, kept for the retire port
		logic pred_taken; // static prediction, backward branch
	} micro_instr_t;

	typedef struct packed {
		logic valid;
		logic taken;
	} bru_res_t;

	typedef struct packed {
		logic valid;
		addr_t target;
	} jalr_res_t;

	typedef struct packed {
		logic valid;
		addr_t pc;
		word_t instr;
		reg_idx_t rd;
		word_t value;
	} retire_t;

endpackage

`default_nettype wire

/* design/rift_params.svh */
`ifndef RIFT_PARAMS_SVH
`define RIFT_PARAMS_SVH

// data and address width
`define RIFT_XLEN 32

// instruction FIFO address bits, 8 entries
`define RIFT_FIFO_AW 3

// branch prediction queue address bits, 4 entries
`define RIFT_BQ_AW 2

// first fetch address after reset
`define RIFT_RESET_PC 32'h0000_0000

`endif
